// ==== src/rca_cfg_pkg.sv ====
`default_nettype none

package rca_cfg_pkg;

    // width of every operand, result and LSQ address or data word.
    localparam int XLEN = 32;

    // shift amounts use the low bits of input 2.
    localparam int SHAMT_W = $clog2(XLEN);

    // entries per operand FIFO. A producer starts with this many credits.
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam int NUM_SLOTS = 2;
    localparam int SLOT_ID_W = 1;

    // one outstanding load per slot.
    localparam int LSQ_TAG_DEPTH = 2;
    localparam int LSQ_TAG_PTR_W = $clog2(LSQ_TAG_DEPTH);

endpackage

`default_nettype wire

// ==== src/rca_op_pkg.sv ====
`default_nettype none

package rca_op_pkg;

    localparam logic KIND_ALU = 1'b0;
    localparam logic KIND_MEM = 1'b1;

    localparam int OFFSET_W = 12;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLL   = 3'd5,
        ALU_SRL   = 3'd6,
        ALU_PASS1 = 3'd7 // only input 1 is consumed.
    } alu_op_e;

    // the ALU view of a configuration word.
    typedef struct packed {
        logic        kind;
        logic [27:0] rsvd;
        alu_op_e     alu_op;
    } slot_alu_cfg_t;

    // the memory view. The offset is added to input 1 to form the address.
    typedef struct packed {
        logic                       kind;
        logic signed [OFFSET_W-1:0] offset;
        logic [14:0]                rsvd;
        logic                       store;
        logic [2:0]                 fn3;
    } slot_mem_cfg_t;

    typedef union packed {
        slot_alu_cfg_t alu;
        slot_mem_cfg_t mem;
    } slot_op_u;

endpackage

`default_nettype wire

// ==== src/operand_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fifo
    import rca_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  logic [XLEN-1:0] data_in,
    input  logic            pop,
    input  logic            drop,
    output logic [XLEN-1:0] data_out,
    output logic            valid,
    output logic            credit
);

    logic [XLEN-1:0]       mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign do_pop = pop && valid;

    assign valid = (count != '0);
    assign data_out = mem[rd_ptr]; // head word is read straight from storage.

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= data_in;
    end

    // depth is a power of two so both pointers wrap on their own.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + FIFO_CNT_W'(do_push) - FIFO_CNT_W'(do_pop);
        end
    end

    // one credit goes back for every freed entry or dropped arrival.
    always_ff @(posedge clk) begin
        if (rst)
            credit <= 1'b0;
        else
            credit <= do_pop || drop;
    end

endmodule

`default_nettype wire

// ==== src/slot_op_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_op_unit
    import rca_cfg_pkg::*;
    import rca_op_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  slot_op_u        cfg,
    input  logic [XLEN-1:0] data_in1,
    input  logic [XLEN-1:0] data_in2,
    input  logic            data_valid_in1,
    input  logic            data_valid_in2,
    input  logic            out_ready,
    input  logic            lsq_grant,
    input  logic [XLEN-1:0] load_data,
    input  logic            load_complete,
    output logic [XLEN-1:0] data_out,
    output logic            data_valid_out,
    output logic            data_in_ack1,
    output logic            data_in_ack2,
    output logic            uses_data_in1,
    output logic            uses_data_in2,
    output logic [XLEN-1:0] addr,
    output logic [XLEN-1:0] data,
    output logic [2:0]      fn3,
    output logic            load,
    output logic            store,
    output logic            new_request
);

    logic            is_mem;
    logic            operands_ready;
    logic            alu_fire;
    logic            mem_fire;
    logic            load_pending;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] offset_ext;

    assign is_mem = (cfg.alu.kind == KIND_MEM); // kind is the same bit in both views.
    assign uses_data_in1 = 1'b1; // every operation reads input 1.
    assign uses_data_in2 = is_mem ? cfg.mem.store : (cfg.alu.alu_op != ALU_PASS1);
    assign operands_ready = data_valid_in1 && (data_valid_in2 || !uses_data_in2);

    always_comb begin
        case (cfg.alu.alu_op)
            ALU_ADD: alu_result = data_in1 + data_in2;
            ALU_SUB: alu_result = data_in1 - data_in2;
            ALU_AND: alu_result = data_in1 & data_in2;
            ALU_OR:  alu_result = data_in1 | data_in2;
            ALU_XOR: alu_result = data_in1 ^ data_in2;
            ALU_SLL: alu_result = data_in1 << data_in2[SHAMT_W-1:0];
            ALU_SRL: alu_result = data_in1 >> data_in2[SHAMT_W-1:0];
            default: alu_result = data_in1;
        endcase
    end

    // ALU results need a downstream credit before they are computed.
    assign alu_fire = !is_mem && operands_ready && out_ready;

    // A load reserves its output credit at issue. Stores never produce output.
    assign new_request = is_mem && operands_ready && !load_pending
                         && (cfg.mem.store || out_ready);
    assign mem_fire = new_request && lsq_grant;

    assign data_in_ack1 = alu_fire || mem_fire;
    assign data_in_ack2 = uses_data_in2 && (alu_fire || mem_fire);

    assign offset_ext = {{(XLEN-OFFSET_W){cfg.mem.offset[OFFSET_W-1]}}, cfg.mem.offset};
    assign addr = data_in1 + offset_ext;
    assign data = data_in2; // store data comes from input 2.
    assign fn3 = cfg.mem.fn3;
    assign load = is_mem && !cfg.mem.store;
    assign store = is_mem && cfg.mem.store;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid_out <= 1'b0;
            load_pending <= 1'b0;
        end else begin
            data_valid_out <= alu_fire || load_complete;
            if (mem_fire && load)
                load_pending <= 1'b1;
            else if (load_complete)
                load_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_fire)
            data_out <= alu_result;
        else if (load_complete)
            data_out <= load_data; // the LSQ returns whole words.
    end

endmodule

`default_nettype wire

// ==== src/slot_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_config_regs
    import rca_cfg_pkg::*;
    import rca_op_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_we,
    input  logic [SLOT_ID_W-1:0] cfg_slot,
    input  logic [XLEN-1:0]      cfg_word,
    output slot_op_u             slot0_cfg,
    output slot_op_u             slot1_cfg
);

    slot_op_u cfg_q [NUM_SLOTS];

    // each slot comes out of reset as an adder.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                cfg_q[i].alu.kind <= KIND_ALU;
                cfg_q[i].alu.rsvd <= '0;
                cfg_q[i].alu.alu_op <= ALU_ADD;
            end
        end else if (cfg_we) begin
            cfg_q[cfg_slot] <= cfg_word; // write is seen by the slot at the next edge.
        end
    end

    assign slot0_cfg = cfg_q[0];
    assign slot1_cfg = cfg_q[1];

endmodule

`default_nettype wire

// ==== src/grid_pr_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module grid_pr_slot
    import rca_cfg_pkg::*;
    import rca_op_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  slot_op_u        cfg,
    input  logic [XLEN-1:0] data_in1,
    input  logic [XLEN-1:0] data_in2,
    input  logic            data_valid_in1,
    input  logic            data_valid_in2,
    input  logic            out_credit,
    input  logic            lsq_grant,
    input  logic [XLEN-1:0] load_data,
    input  logic            load_complete,
    output logic            in1_credit,
    output logic            in2_credit,
    output logic [XLEN-1:0] data_out,
    output logic            data_valid_out,
    output logic [XLEN-1:0] addr,
    output logic [XLEN-1:0] data,
    output logic [2:0]      fn3,
    output logic            load,
    output logic            store,
    output logic            new_request
);

    logic [XLEN-1:0]       fifo1_data;
    logic [XLEN-1:0]       fifo2_data;
    logic                  fifo1_valid;
    logic                  fifo2_valid;
    logic                  ack1;
    logic                  ack2;
    logic                  uses_data_in1;
    logic                  uses_data_in2;
    logic                  out_ready;
    logic [FIFO_CNT_W-1:0] credit_cnt;
    logic [FIFO_CNT_W-1:0] credit_next;

    // operands for an input the operation ignores are dropped right away.
    operand_fifo input1_fifo (
        .clk, .rst,
        .push(data_valid_in1 && uses_data_in1),
        .data_in(data_in1),
        .pop(ack1),
        .drop(data_valid_in1 && !uses_data_in1),
        .data_out(fifo1_data),
        .valid(fifo1_valid),
        .credit(in1_credit)
    );

    operand_fifo input2_fifo (
        .clk, .rst,
        .push(data_valid_in2 && uses_data_in2),
        .data_in(data_in2),
        .pop(ack2),
        .drop(data_valid_in2 && !uses_data_in2),
        .data_out(fifo2_data),
        .valid(fifo2_valid),
        .credit(in2_credit)
    );

    // a credit is spent on the output beat. The beat in flight is already committed.
    always_comb begin
        credit_next = credit_cnt + FIFO_CNT_W'(out_credit) - FIFO_CNT_W'(data_valid_out);
        if (credit_next > FIFO_CNT_W'(FIFO_DEPTH))
            credit_next = FIFO_CNT_W'(FIFO_DEPTH); // saturates when the credit line is tied high.
    end

    always_ff @(posedge clk) begin
        if (rst)
            credit_cnt <= FIFO_CNT_W'(FIFO_DEPTH);
        else
            credit_cnt <= credit_next;
    end

    assign out_ready = (credit_cnt > FIFO_CNT_W'(data_valid_out));

    slot_op_unit ou (
        .clk, .rst, .cfg,
        .data_in1(fifo1_data),
        .data_in2(fifo2_data),
        .data_valid_in1(fifo1_valid),
        .data_valid_in2(fifo2_valid),
        .out_ready, .lsq_grant, .load_data, .load_complete,
        .data_out, .data_valid_out,
        .data_in_ack1(ack1),
        .data_in_ack2(ack2),
        .uses_data_in1, .uses_data_in2,
        .addr, .data, .fn3, .load, .store, .new_request
    );

endmodule

`default_nettype wire

// ==== src/lsq_port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_port_arbiter
    import rca_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] addr0,
    input  logic [XLEN-1:0] data0,
    input  logic [2:0]      fn3_0,
    input  logic            load0,
    input  logic            store0,
    input  logic            req0,
    input  logic [XLEN-1:0] addr1,
    input  logic [XLEN-1:0] data1,
    input  logic [2:0]      fn3_1,
    input  logic            load1,
    input  logic            store1,
    input  logic            req1,
    input  logic            lsq_full,
    input  logic [XLEN-1:0] lsq_load_data,
    input  logic            lsq_load_complete,
    output logic            grant0,
    output logic            grant1,
    output logic            load_complete0,
    output logic            load_complete1,
    output logic [XLEN-1:0] load_data,
    output logic [XLEN-1:0] lsq_addr,
    output logic [XLEN-1:0] lsq_data,
    output logic [2:0]      lsq_fn3,
    output logic            lsq_load,
    output logic            lsq_store,
    output logic            lsq_new_request
);

    logic [SLOT_ID_W-1:0]     tag_q [LSQ_TAG_DEPTH];
    logic [LSQ_TAG_PTR_W-1:0] tag_wr_ptr;
    logic [LSQ_TAG_PTR_W-1:0] tag_rd_ptr;
    logic                     tag_push;

    assign grant1 = req1 && !lsq_full; // slot 1 wins so the downstream slot drains first.
    assign grant0 = req0 && !lsq_full && !req1;

    assign lsq_new_request = grant0 || grant1;
    assign lsq_addr = grant1 ? addr1 : addr0;
    assign lsq_data = grant1 ? data1 : data0;
    assign lsq_fn3 = grant1 ? fn3_1 : fn3_0;
    assign lsq_load = grant1 ? load1 : load0;
    assign lsq_store = grant1 ? store1 : store0;

    // completions come back in issue order, so a tag queue is enough.
    assign tag_push = lsq_new_request && lsq_load;

    always_ff @(posedge clk) begin
        if (tag_push)
            tag_q[tag_wr_ptr] <= SLOT_ID_W'(grant1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_wr_ptr <= '0;
            tag_rd_ptr <= '0;
        end else begin
            if (tag_push)
                tag_wr_ptr <= tag_wr_ptr + 1'b1;
            if (lsq_load_complete)
                tag_rd_ptr <= tag_rd_ptr + 1'b1;
        end
    end

    assign load_complete0 = lsq_load_complete && (tag_q[tag_rd_ptr] == SLOT_ID_W'(0));
    assign load_complete1 = lsq_load_complete && (tag_q[tag_rd_ptr] == SLOT_ID_W'(1));
    assign load_data = lsq_load_data; // only the slot with the pulse takes it.

endmodule

`default_nettype wire

// ==== src/rca_grid.sv ====
`timescale 1ns/1ps
`default_nettype none

module rca_grid
    import rca_cfg_pkg::*;
    import rca_op_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_we,
    input  logic [SLOT_ID_W-1:0] cfg_slot,
    input  logic [XLEN-1:0]      cfg_word,
    input  logic                 a_in1_valid,
    input  logic [XLEN-1:0]      a_in1_data,
    output logic                 a_in1_credit,
    input  logic                 a_in2_valid,
    input  logic [XLEN-1:0]      a_in2_data,
    output logic                 a_in2_credit,
    input  logic                 b_in2_valid,
    input  logic [XLEN-1:0]      b_in2_data,
    output logic                 b_in2_credit,
    output logic [XLEN-1:0]      lsq_addr,
    output logic [XLEN-1:0]      lsq_data,
    output logic [2:0]           lsq_fn3,
    output logic                 lsq_load,
    output logic                 lsq_store,
    output logic                 lsq_new_request,
    input  logic                 lsq_full,
    input  logic [XLEN-1:0]      lsq_load_data,
    input  logic                 lsq_load_complete,
    output logic [XLEN-1:0]      data_out,
    output logic                 data_valid_out
);

    slot_op_u        slot_cfg [NUM_SLOTS];
    logic [XLEN-1:0] s0_data;
    logic            s0_valid;
    logic            s1_in1_credit;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] addr0, addr1, data0, data1;
    logic [2:0]      fn3_0, fn3_1;
    logic            load0, load1, store0, store1, req0, req1;
    logic            grant0, grant1, load_complete0, load_complete1;

    slot_config_regs cfg_regs (
        .clk, .rst, .cfg_we, .cfg_slot, .cfg_word,
        .slot0_cfg(slot_cfg[0]),
        .slot1_cfg(slot_cfg[1])
    );

    grid_pr_slot slot0 (
        .clk, .rst, .cfg(slot_cfg[0]),
        .data_in1(a_in1_data), .data_in2(a_in2_data),
        .data_valid_in1(a_in1_valid), .data_valid_in2(a_in2_valid),
        .out_credit(s1_in1_credit),
        .lsq_grant(grant0), .load_data, .load_complete(load_complete0),
        .in1_credit(a_in1_credit), .in2_credit(a_in2_credit),
        .data_out(s0_data), .data_valid_out(s0_valid),
        .addr(addr0), .data(data0), .fn3(fn3_0),
        .load(load0), .store(store0), .new_request(req0)
    );

    // the sink always accepts, so slot 1 gets a credit back every cycle.
    grid_pr_slot slot1 (
        .clk, .rst, .cfg(slot_cfg[1]),
        .data_in1(s0_data), .data_in2(b_in2_data),
        .data_valid_in1(s0_valid), .data_valid_in2(b_in2_valid),
        .out_credit(1'b1),
        .lsq_grant(grant1), .load_data, .load_complete(load_complete1),
        .in1_credit(s1_in1_credit), .in2_credit(b_in2_credit),
        .data_out, .data_valid_out,
        .addr(addr1), .data(data1), .fn3(fn3_1),
        .load(load1), .store(store1), .new_request(req1)
    );

    lsq_port_arbiter lsq_arb (
        .clk, .rst,
        .addr0, .data0, .fn3_0, .load0, .store0, .req0,
        .addr1, .data1, .fn3_1, .load1, .store1, .req1,
        .lsq_full, .lsq_load_data, .lsq_load_complete,
        .grant0, .grant1, .load_complete0, .load_complete1, .load_data,
        .lsq_addr, .lsq_data, .lsq_fn3, .lsq_load, .lsq_store, .lsq_new_request
    );

endmodule

`default_nettype wire

// ==== verif/rca_grid_model.svh ====
`ifndef RCA_GRID_MODEL_SVH
`define RCA_GRID_MODEL_SVH

logic [31:0]     rng_state = 32'h3343;
logic [XLEN-1:0] mem_words [256];
logic [XLEN-1:0] exp_out [$];
logic [XLEN-1:0] exp_st_addr [$];
logic [XLEN-1:0] exp_st_data [$];
logic [2:0]      exp_st_fn3 [$];
int              exp_loads;

function automatic logic [31:0] xorshift_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// the word the LSQ returns depends on every address bit.
function automatic logic [XLEN-1:0] load_word(logic [XLEN-1:0] a);
    return mem_words[a[9:2]] ^ a;
endfunction

function automatic logic [XLEN-1:0] alu_model(alu_op_e op, logic [XLEN-1:0] x,
                                              logic [XLEN-1:0] y);
    case (op)
        ALU_ADD: return x + y;
        ALU_SUB: return x - y;
        ALU_AND: return x & y;
        ALU_OR:  return x | y;
        ALU_XOR: return x ^ y;
        ALU_SLL: return x << y[4:0];
        ALU_SRL: return x >> y[4:0];
        default: return x; // pass of input 1.
    endcase
endfunction

function automatic logic uses_in2(slot_op_u c);
    if (c.alu.kind == KIND_MEM)
        return c.mem.store; // a load only takes the address operand.
    return c.alu.alu_op != ALU_PASS1;
endfunction

// one slot pairs its two operand streams in order and fills its result list.
task automatic slot_model(input slot_op_u c, ref logic [XLEN-1:0] in1 [$],
                          ref logic [XLEN-1:0] in2 [$], ref logic [XLEN-1:0] res [$]);
    logic [XLEN-1:0] y;
    logic [XLEN-1:0] addr;
    for (int i = 0; i < in1.size(); i++) begin
        y = uses_in2(c) ? in2[i] : '0;
        if (c.alu.kind == KIND_ALU) begin
            res.push_back(alu_model(c.alu.alu_op, in1[i], y));
        end else begin
            addr = in1[i] + {{(XLEN-12){c.mem.offset[11]}}, c.mem.offset};
            if (c.mem.store) begin
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(y);
                exp_st_fn3.push_back(c.mem.fn3);
            end else begin
                exp_loads++;
                res.push_back(load_word(addr));
            end
        end
    end
endtask

task automatic build_expected(input slot_op_u c0, input slot_op_u c1,
                              ref logic [XLEN-1:0] a1 [$], ref logic [XLEN-1:0] a2 [$],
                              ref logic [XLEN-1:0] b2 [$]);
    logic [XLEN-1:0] s0 [$];
    exp_loads = 0;
    slot_model(c0, a1, a2, s0);
    slot_model(c1, s0, b2, exp_out); // slot 0 results feed input 1 of slot 1.
endtask

`endif

// ==== verif/rca_grid_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rca_grid_tb
    import rca_cfg_pkg::*;
    import rca_op_pkg::*;
();

    logic                 clk;
    logic                 rst;
    logic                 cfg_we;
    logic [SLOT_ID_W-1:0] cfg_slot;
    logic [XLEN-1:0]      cfg_word;
    logic                 a_in1_valid, a_in2_valid, b_in2_valid;
    logic [XLEN-1:0]      a_in1_data, a_in2_data, b_in2_data;
    logic                 a_in1_credit, a_in2_credit, b_in2_credit;
    logic [XLEN-1:0]      lsq_addr, lsq_data, lsq_load_data, data_out;
    logic [2:0]           lsq_fn3;
    logic                 lsq_load, lsq_store, lsq_new_request;
    logic                 lsq_full, lsq_load_complete, data_valid_out;

    `include "rca_grid_model.svh"

    logic [XLEN-1:0] q_a1 [$];
    logic [XLEN-1:0] q_a2 [$];
    logic [XLEN-1:0] q_b2 [$];
    logic [XLEN-1:0] ld_addr [$];
    int              ld_ready [$];
    int              cr_a1, cr_a2, cr_b2;
    int              cycle, b2_start, ld_issued;
    int              errors, tests_run, tests_failed;
    bit              burst, timed_out;
    logic [31:0]     r;

    rca_grid rca_grid_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic check_credit(input string name, input int cnt);
        assert (cnt >= 0 && cnt <= FIFO_DEPTH) else begin
            $display("credit counter of %s left its range at %0t: %0d", name, $time, cnt);
            errors++;
        end
    endtask

    // a producer may only send while it holds a credit.
    task automatic drive_channel(ref int cr, ref logic [XLEN-1:0] q [$], input bit go,
                                 output logic v, output logic [XLEN-1:0] d);
        if (go && q.size() > 0 && cr > 0) begin
            v = 1'b1;
            d = q.pop_front();
            cr--;
        end else begin
            v = 1'b0;
            d = xorshift_next(); // junk data while idle.
        end
    endtask

    task automatic check_request();
        if (!lsq_new_request)
            return;
        assert (!lsq_full) else begin
            $display("request issued while lsq_full was high at %0t", $time);
            errors++;
        end
        if (lsq_load) begin
            ld_issued++;
            ld_addr.push_back(lsq_addr);
            ld_ready.push_back(cycle + 1 + int'(r[9:8]) + int'(r[11:10]));
        end else if (lsq_store) begin
            assert (exp_st_addr.size() > 0) else begin
                $display("unexpected store to %h at %0t", lsq_addr, $time);
                errors++;
            end
            if (exp_st_addr.size() > 0) begin
                assert (lsq_addr == exp_st_addr[0])
                    else report_mismatch("lsq_addr", lsq_addr, exp_st_addr[0]);
                assert (lsq_data == exp_st_data[0])
                    else report_mismatch("lsq_data", lsq_data, exp_st_data[0]);
                assert (lsq_fn3 == exp_st_fn3[0])
                    else report_mismatch("lsq_fn3", 32'(lsq_fn3), 32'(exp_st_fn3[0]));
                void'(exp_st_addr.pop_front());
                void'(exp_st_data.pop_front());
                void'(exp_st_fn3.pop_front());
            end
        end
    endtask

    // each clock samples registered outputs, drives inputs and then checks the LSQ request.
    task automatic step_cycle();
        @(negedge clk);
        cycle++;
        r = xorshift_next();
        cr_a1 += int'(a_in1_credit);
        cr_a2 += int'(a_in2_credit);
        cr_b2 += int'(b_in2_credit);
        check_credit("a_in1", cr_a1);
        check_credit("a_in2", cr_a2);
        check_credit("b_in2", cr_b2);
        if (data_valid_out) begin
            assert (exp_out.size() > 0) else begin
                $display("unexpected output %h on data_out at %0t", data_out, $time);
                errors++;
            end
            if (exp_out.size() > 0) begin
                assert (data_out == exp_out[0])
                    else report_mismatch("data_out", data_out, exp_out[0]);
                void'(exp_out.pop_front());
            end
        end
        drive_channel(cr_a1, q_a1, burst || r[0], a_in1_valid, a_in1_data);
        drive_channel(cr_a2, q_a2, burst || r[1], a_in2_valid, a_in2_data);
        drive_channel(cr_b2, q_b2, (burst || r[2]) && cycle >= b2_start, b_in2_valid,
                      b_in2_data);
        lsq_load_complete = 1'b0;
        if (ld_addr.size() > 0 && cycle >= ld_ready[0]) begin
            lsq_load_complete = 1'b1; // loads complete in issue order.
            lsq_load_data = load_word(ld_addr.pop_front());
            void'(ld_ready.pop_front());
        end
        lsq_full = (r[5:4] == 2'b00);
        #2;
        check_request();
    endtask

    function automatic bit grid_drained();
        return q_a1.size() == 0 && q_a2.size() == 0 && q_b2.size() == 0
            && exp_out.size() == 0 && exp_st_addr.size() == 0 && ld_addr.size() == 0
            && cr_a1 == FIFO_DEPTH && cr_a2 == FIFO_DEPTH && cr_b2 == FIFO_DEPTH;
    endfunction

    task automatic write_cfg(input logic [SLOT_ID_W-1:0] s, input slot_op_u w);
        @(negedge clk);
        cfg_we = 1'b1;
        cfg_slot = s;
        cfg_word = w;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    function automatic slot_op_u alu_cfg(alu_op_e op);
        slot_op_u c;
        c = '0;
        c.alu.kind = KIND_ALU;
        c.alu.alu_op = op;
        return c;
    endfunction

    function automatic slot_op_u mem_cfg(logic st, logic [11:0] off, logic [2:0] f);
        slot_op_u c;
        c = '0;
        c.mem.kind = KIND_MEM;
        c.mem.offset = off;
        c.mem.store = st;
        c.mem.fn3 = f;
        return c;
    endfunction

    function automatic alu_op_e two_input_op();
        return alu_op_e'(3'(xorshift_next() % 32'd7)); // never the pass operation.
    endfunction

    task automatic run_test(input string name, input slot_op_u c0, input slot_op_u c1,
                            input bit bp);
        logic [XLEN-1:0] a1 [$];
        logic [XLEN-1:0] a2 [$];
        logic [XLEN-1:0] b2 [$];
        int              n;
        int              start_errors;
        int              wait_cycles;
        start_errors = errors;
        n = 8 + int'(xorshift_next() % 32'd24);
        write_cfg(1'b0, c0); // the grid is idle here.
        write_cfg(1'b1, c1);
        for (int i = 0; i < n; i++) begin
            a1.push_back(xorshift_next());
            a2.push_back(xorshift_next());
            b2.push_back(xorshift_next());
        end
        build_expected(c0, c1, a1, a2, b2);
        q_a1 = a1;
        q_a2 = a2;
        q_b2 = b2;
        ld_issued = 0;
        burst = bp;
        b2_start = cycle + (bp ? 40 : 0); // a late b_in2 makes the whole grid back up.
        wait_cycles = 0;
        while (!grid_drained() && !timed_out) begin
            step_cycle();
            wait_cycles++;
            if (wait_cycles > 4000) begin
                $display("timeout: test %s did not drain within 4000 cycles", name);
                timed_out = 1'b1;
            end
        end
        repeat (10) step_cycle(); // any late extra output is caught here.
        assert (ld_issued == exp_loads) else begin
            $display("test %s issued %0d loads instead of %0d", name, ld_issued, exp_loads);
            errors++;
        end
        tests_run++;
        if (errors != start_errors || timed_out)
            tests_failed++;
        $display("test %s: %0d items, %0d errors", name, n, errors - start_errors);
    endtask

    initial begin
        rst = 1'b1;
        cfg_we = 1'b0;
        cfg_slot = '0;
        cfg_word = '0;
        a_in1_valid = 1'b0;
        a_in2_valid = 1'b0;
        b_in2_valid = 1'b0;
        a_in1_data = '0;
        a_in2_data = '0;
        b_in2_data = '0;
        lsq_full = 1'b0;
        lsq_load_data = '0;
        lsq_load_complete = 1'b0;
        cr_a1 = FIFO_DEPTH;
        cr_a2 = FIFO_DEPTH;
        cr_b2 = FIFO_DEPTH;
        for (int i = 0; i < 256; i++)
            mem_words[i] = xorshift_next();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int k = 0; k < 3; k++) begin
            r = xorshift_next();
            if (!timed_out)
                run_test("alu chain", alu_cfg(alu_op_e'(r[2:0])),
                         alu_cfg(alu_op_e'(r[6:4])), 1'b0);
        end
        if (!timed_out)
            run_test("credit back-pressure", alu_cfg(two_input_op()), alu_cfg(two_input_op()), 1'b1);
        if (!timed_out)
            run_test("load from alu address", alu_cfg(two_input_op()),
                     mem_cfg(1'b0, 12'(xorshift_next()), 3'b010), 1'b0);
        if (!timed_out)
            run_test("store in slot 0", mem_cfg(1'b1, 12'(xorshift_next()), 3'(xorshift_next())),
                     alu_cfg(ALU_PASS1), 1'b0);
        if (!timed_out)
            run_test("store in slot 1", alu_cfg(two_input_op()),
                     mem_cfg(1'b1, 12'(xorshift_next()), 3'(xorshift_next())), 1'b0);
        if (!timed_out)
            run_test("dropped operands", alu_cfg(ALU_PASS1), alu_cfg(two_input_op()), 1'b0);
        if (!timed_out)
            run_test("loads in both slots", mem_cfg(1'b0, 12'(xorshift_next()), 3'b010),
                     mem_cfg(1'b0, 12'(xorshift_next()), 3'b010), 1'b0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verif
src/rca_cfg_pkg.sv
src/rca_op_pkg.sv
src/operand_fifo.sv
src/slot_op_unit.sv
src/slot_config_regs.sv
src/grid_pr_slot.sv
src/lsq_port_arbiter.sv
src/rca_grid.sv
verif/rca_grid_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f filelist.f --top-module rca_grid_tb -o rca_grid_sim

sim_out=$(./obj_dir/rca_grid_sim)
echo "$sim_out"

if grep -qx "sim passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
